//--- verilog/errt_pkg.sv
package errt_pkg;

    // lanes per frame and the width of each per-lane field
    localparam int LANES = 16;
    localparam int ERR_W = 8;
    localparam int FLAG_W = 2;

    // the capture store holds 2**ADDR_W records
    localparam int ADDR_W = 3;

    // trigger threshold mode, a mode of m needs more than m PRBS flags
    localparam int MODE_W = 2;

    // record frame number and saturating drop counter
    localparam int FRAME_W = 16;
    localparam int DROP_W = 8;

    // largest number of credits the consumer may have outstanding
    localparam int CREDIT_MAX = 4;

    // frames per capture window: one before, the trigger frame, one after
    localparam int WIN = 3;

endpackage

//--- verilog/history_buffer.sv
`timescale 1ns/10ps

module history_buffer #(
    parameter type frame_t = logic [7:0],
    parameter int  DEPTH   = 3
) (
    input  logic   clk,
    input  logic   rstb,
    input  frame_t frame_i,
    output frame_t hist_o [DEPTH]
);

    frame_t hist_q [DEPTH];

    // stage 0 holds the newest frame, each edge moves every frame one stage older
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            for (int i = 0; i < DEPTH; i++) begin
                hist_q[i] <= '0;
            end
        end else begin
            hist_q[0] <= frame_i;
            for (int i = 1; i < DEPTH; i++) begin
                hist_q[i] <= hist_q[i-1];
            end
        end
    end

    assign hist_o = hist_q;

endmodule

//--- verilog/error_tracker.sv
`timescale 1ns/10ps

module error_tracker
    import errt_pkg::*;
#(
    parameter int LANES  = errt_pkg::LANES,
    parameter int ERR_W  = errt_pkg::ERR_W,
    parameter int FLAG_W = errt_pkg::FLAG_W
) (
    input  logic                         clk,
    input  logic                         rstb,
    input  logic [MODE_W-1:0]            mode_i,
    input  logic [LANES-1:0]             prbs_flags_i,
    input  logic [LANES-1:0]             sliced_bits_i,
    input  logic [LANES-1:0][ERR_W-1:0]  est_error_i,
    input  logic [LANES-1:0][FLAG_W-1:0] sd_flags_i,
    output logic                         cap_o,
    output logic [LANES-1:0]             cap_frame_prbs_o,
    output logic [WIN*LANES-1:0]         cap_bits_o,
    output logic [WIN*LANES*ERR_W-1:0]   cap_error_o,
    output logic [WIN*LANES*FLAG_W-1:0]  cap_sdflags_o
);

    localparam int CNT_W = $clog2(LANES + 1);

    // error fields are two's complement, the sign is only interpreted downstream
    typedef logic [LANES-1:0]             lane_bits_t;
    typedef logic [LANES-1:0][ERR_W-1:0]  lane_error_t;
    typedef logic [LANES-1:0][FLAG_W-1:0] lane_flags_t;

    lane_bits_t  bits_hist    [WIN];
    lane_bits_t  prbs_hist    [WIN];
    lane_error_t error_hist   [WIN];
    lane_flags_t sdflags_hist [WIN];

    logic [CNT_W-1:0] ones;
    logic             trig_c;
    logic             trig_q;

    history_buffer #(.frame_t(lane_bits_t), .DEPTH(WIN)) u_bits_hist (
        .clk     (clk),
        .rstb    (rstb),
        .frame_i (sliced_bits_i),
        .hist_o  (bits_hist)
    );

    history_buffer #(.frame_t(lane_error_t), .DEPTH(WIN)) u_error_hist (
        .clk     (clk),
        .rstb    (rstb),
        .frame_i (est_error_i),
        .hist_o  (error_hist)
    );

    history_buffer #(.frame_t(lane_flags_t), .DEPTH(WIN)) u_sdflags_hist (
        .clk     (clk),
        .rstb    (rstb),
        .frame_i (sd_flags_i),
        .hist_o  (sdflags_hist)
    );

    history_buffer #(.frame_t(lane_bits_t), .DEPTH(WIN)) u_prbs_hist (
        .clk     (clk),
        .rstb    (rstb),
        .frame_i (prbs_flags_i),
        .hist_o  (prbs_hist)
    );

    // popcount of the newest registered PRBS flags against the mode threshold
    always_comb begin
        ones = '0;
        for (int i = 0; i < LANES; i++) begin
            ones = ones + CNT_W'(prbs_hist[0][i]);
        end
        trig_c = ones > CNT_W'(mode_i);
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            trig_q <= 1'b0;
        end else begin
            trig_q <= trig_c;
        end
    end

    // by the time trig_q is high the trigger frame has moved to stage 1
    assign cap_o            = trig_q;
    assign cap_frame_prbs_o = prbs_hist[1];

    // oldest frame (stage 2) lands in the low positions
    assign cap_bits_o    = {bits_hist[0], bits_hist[1], bits_hist[2]};
    assign cap_error_o   = {error_hist[0], error_hist[1], error_hist[2]};
    assign cap_sdflags_o = {sdflags_hist[0], sdflags_hist[1], sdflags_hist[2]};

endmodule

//--- verilog/capture_store.sv
`timescale 1ns/10ps

module capture_store
    import errt_pkg::*;
#(
    parameter int LANES  = errt_pkg::LANES,
    parameter int ERR_W  = errt_pkg::ERR_W,
    parameter int FLAG_W = errt_pkg::FLAG_W,
    parameter int ADDR_W = errt_pkg::ADDR_W
) (
    input  logic                        clk,
    input  logic                        rstb,
    input  logic                        cap_i,
    input  logic [LANES-1:0]            cap_frame_prbs_i,
    input  logic [WIN*LANES-1:0]        cap_bits_i,
    input  logic [WIN*LANES*ERR_W-1:0]  cap_error_i,
    input  logic [WIN*LANES*FLAG_W-1:0] cap_sdflags_i,
    input  logic                        rd_en_i,
    output logic                        avail_o,
    output logic [DROP_W-1:0]           drop_count_o,
    output logic [FRAME_W-1:0]          rec_frame_o,
    output logic [LANES-1:0]            rec_prbs_o,
    output logic [WIN*LANES-1:0]        rec_bits_o,
    output logic [WIN*LANES*ERR_W-1:0]  rec_error_o,
    output logic [WIN*LANES*FLAG_W-1:0] rec_sdflags_o
);

    localparam int DEPTH = 1 << ADDR_W;
    // cycles from a frame entering the tracker to its cap_i strobe
    localparam int CAP_LAT = 2;

    logic [FRAME_W-1:0] frame_cnt;
    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [ADDR_W:0]    count;
    logic               full;
    logic               wr_en;
    logic               rd_en;
    logic               drop;

    logic [FRAME_W-1:0]          mem_frame   [DEPTH];
    logic [LANES-1:0]            mem_prbs    [DEPTH];
    logic [WIN*LANES-1:0]        mem_bits    [DEPTH];
    logic [WIN*LANES*ERR_W-1:0]  mem_error   [DEPTH];
    logic [WIN*LANES*FLAG_W-1:0] mem_sdflags [DEPTH];

    assign full    = (count == (ADDR_W + 1)'(DEPTH));
    assign avail_o = (count != '0);
    assign wr_en   = cap_i && !full;
    assign drop    = cap_i && full;
    assign rd_en   = rd_en_i && avail_o;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            frame_cnt    <= '0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            drop_count_o <= '0;
        end else begin
            frame_cnt <= frame_cnt + 1'b1;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // saturates at all ones
            if (drop && (drop_count_o != '1)) begin
                drop_count_o <= drop_count_o + 1'b1;
            end
        end
    end

    // the counter runs CAP_LAT frames ahead of the trigger frame
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_frame[wr_ptr]   <= frame_cnt - FRAME_W'(CAP_LAT);
            mem_prbs[wr_ptr]    <= cap_frame_prbs_i;
            mem_bits[wr_ptr]    <= cap_bits_i;
            mem_error[wr_ptr]   <= cap_error_i;
            mem_sdflags[wr_ptr] <= cap_sdflags_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rec_frame_o   <= mem_frame[rd_ptr];
            rec_prbs_o    <= mem_prbs[rd_ptr];
            rec_bits_o    <= mem_bits[rd_ptr];
            rec_error_o   <= mem_error[rd_ptr];
            rec_sdflags_o <= mem_sdflags[rd_ptr];
        end
    end

endmodule

//--- verilog/record_readout.sv
`timescale 1ns/10ps

module record_readout #(
    parameter int CREDIT_MAX = errt_pkg::CREDIT_MAX
) (
    input  logic clk,
    input  logic rstb,
    input  logic credit_i,
    input  logic avail_i,
    output logic rd_en_o,
    output logic rec_valid_o
);

    localparam int CRED_W = $clog2(CREDIT_MAX + 1);

    logic [CRED_W-1:0] credit_cnt;

    // a pop needs a stored record and a credit to spend on it
    assign rd_en_o = avail_i && (credit_cnt != '0);

    // a returned credit and a pop in the same cycle cancel out
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            credit_cnt <= '0;
        end else begin
            credit_cnt <= credit_cnt + CRED_W'(credit_i) - CRED_W'(rd_en_o);
        end
    end

    // the store answers a pop one cycle later, so valid is simply the delayed pop
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            rec_valid_o <= 1'b0;
        end else begin
            rec_valid_o <= rd_en_o;
        end
    end

endmodule

//--- verilog/errt_top.sv
`timescale 1ns/10ps

module errt_top
    import errt_pkg::*;
#(
    parameter int LANES      = errt_pkg::LANES,
    parameter int ERR_W      = errt_pkg::ERR_W,
    parameter int FLAG_W     = errt_pkg::FLAG_W,
    parameter int ADDR_W     = errt_pkg::ADDR_W,
    parameter int CREDIT_MAX = errt_pkg::CREDIT_MAX
) (
    input  logic                         clk,
    input  logic                         rstb,
    input  logic [MODE_W-1:0]            mode_i,
    input  logic [LANES-1:0]             prbs_flags_i,
    input  logic [LANES-1:0]             sliced_bits_i,
    input  logic [LANES-1:0][ERR_W-1:0]  est_error_i,
    input  logic [LANES-1:0][FLAG_W-1:0] sd_flags_i,
    input  logic                         credit_i,
    output logic                         rec_valid_o,
    output logic [FRAME_W-1:0]           rec_frame_o,
    output logic [LANES-1:0]             rec_prbs_o,
    output logic [WIN*LANES-1:0]         rec_bits_o,
    output logic [WIN*LANES*ERR_W-1:0]   rec_error_o,
    output logic [WIN*LANES*FLAG_W-1:0]  rec_sdflags_o,
    output logic [DROP_W-1:0]            drop_count_o
);

    logic                        cap;
    logic [LANES-1:0]            cap_frame_prbs;
    logic [WIN*LANES-1:0]        cap_bits;
    logic [WIN*LANES*ERR_W-1:0]  cap_error;
    logic [WIN*LANES*FLAG_W-1:0] cap_sdflags;
    logic                        rd_en;
    logic                        avail;

    error_tracker #(
        .LANES  (LANES),
        .ERR_W  (ERR_W),
        .FLAG_W (FLAG_W)
    ) u_tracker (
        .clk              (clk),
        .rstb             (rstb),
        .mode_i           (mode_i),
        .prbs_flags_i     (prbs_flags_i),
        .sliced_bits_i    (sliced_bits_i),
        .est_error_i      (est_error_i),
        .sd_flags_i       (sd_flags_i),
        .cap_o            (cap),
        .cap_frame_prbs_o (cap_frame_prbs),
        .cap_bits_o       (cap_bits),
        .cap_error_o      (cap_error),
        .cap_sdflags_o    (cap_sdflags)
    );

    capture_store #(
        .LANES  (LANES),
        .ERR_W  (ERR_W),
        .FLAG_W (FLAG_W),
        .ADDR_W (ADDR_W)
    ) u_store (
        .clk              (clk),
        .rstb             (rstb),
        .cap_i            (cap),
        .cap_frame_prbs_i (cap_frame_prbs),
        .cap_bits_i       (cap_bits),
        .cap_error_i      (cap_error),
        .cap_sdflags_i    (cap_sdflags),
        .rd_en_i          (rd_en),
        .avail_o          (avail),
        .drop_count_o     (drop_count_o),
        .rec_frame_o      (rec_frame_o),
        .rec_prbs_o       (rec_prbs_o),
        .rec_bits_o       (rec_bits_o),
        .rec_error_o      (rec_error_o),
        .rec_sdflags_o    (rec_sdflags_o)
    );

    record_readout #(
        .CREDIT_MAX (CREDIT_MAX)
    ) u_readout (
        .clk         (clk),
        .rstb        (rstb),
        .credit_i    (credit_i),
        .avail_i     (avail),
        .rd_en_o     (rd_en),
        .rec_valid_o (rec_valid_o)
    );

endmodule

//--- tb/errt_asserts.sv
`timescale 1ns/10ps

module errt_asserts #(
    parameter int CREDIT_MAX = errt_pkg::CREDIT_MAX,
    parameter int CRED_W     = $clog2(CREDIT_MAX + 1)
) (
    input logic              clk,
    input logic              rstb,
    input logic              credit_i,
    input logic [CRED_W-1:0] credit_cnt_i,
    input logic              rd_en_i,
    input logic              rec_valid_i
);

    int fail_count;
    int credits_seen;
    int pops_seen;

    // credits returned and pops issued since reset, taken from the ports alone
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            credits_seen <= 0;
            pops_seen    <= 0;
        end else begin
            credits_seen <= credits_seen + int'(credit_i);
            pops_seen    <= pops_seen + int'(rd_en_i);
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (!rstb)
        credit_cnt_i <= CRED_W'(CREDIT_MAX))
        else begin
            fail_count++;
            $error("credit count is above the credit limit");
        end

    // every pop must be paid by a credit returned at an earlier edge
    pop_needs_credit: assert property (@(posedge clk) disable iff (!rstb)
        rd_en_i |-> (credits_seen > pops_seen))
        else begin
            fail_count++;
            $error("record popped with no credit held");
        end

    valid_low_after_reset: assert property (@(posedge clk)
        $rose(rstb) |-> !rec_valid_i)
        else begin
            fail_count++;
            $error("record valid high right after reset");
        end

endmodule

bind record_readout errt_asserts #(
    .CREDIT_MAX (CREDIT_MAX)
) u_asserts (
    .clk          (clk),
    .rstb         (rstb),
    .credit_i     (credit_i),
    .credit_cnt_i (credit_cnt),
    .rd_en_i      (rd_en_o),
    .rec_valid_i  (rec_valid_o)
);

//--- tb/errt_checker.sv
`timescale 1ns/10ps

module errt_checker
    import errt_pkg::*;
#(
    parameter int LANES  = errt_pkg::LANES,
    parameter int ERR_W  = errt_pkg::ERR_W,
    parameter int FLAG_W = errt_pkg::FLAG_W,
    parameter int ADDR_W = errt_pkg::ADDR_W
) (
    input  logic                         clk,
    input  logic                         rstb,
    input  logic [MODE_W-1:0]            mode_i,
    input  logic [LANES-1:0]             prbs_flags_i,
    input  logic [LANES-1:0]             sliced_bits_i,
    input  logic [LANES-1:0][ERR_W-1:0]  est_error_i,
    input  logic [LANES-1:0][FLAG_W-1:0] sd_flags_i,
    input  logic                         credit_i,
    input  logic                         rec_valid_i,
    input  logic [FRAME_W-1:0]           rec_frame_i,
    input  logic [LANES-1:0]             rec_prbs_i,
    input  logic [WIN*LANES-1:0]         rec_bits_i,
    input  logic [WIN*LANES*ERR_W-1:0]   rec_error_i,
    input  logic [WIN*LANES*FLAG_W-1:0]  rec_sdflags_i,
    input  logic [DROP_W-1:0]            drop_count_i,
    output logic [31:0]                  err_count_o,
    output logic [31:0]                  rec_count_o,
    output logic [31:0]                  drop_count_o,
    output logic [31:0]                  pending_o
);

    localparam int DEPTH    = 1 << ADDR_W;
    localparam int DROP_MAX = (1 << DROP_W) - 1;

    // model history, index 0 is the newest frame
    logic [LANES-1:0]        bits_h [WIN];
    logic [LANES-1:0]        prbs_h [WIN];
    logic [LANES*ERR_W-1:0]  err_h  [WIN];
    logic [LANES*FLAG_W-1:0] sd_h   [WIN];

    logic [FRAME_W-1:0]          frame_n;
    logic                        wr_pend;
    logic                        credit_d;
    logic [FRAME_W-1:0]          pend_frame;
    logic [LANES-1:0]            pend_prbs;
    logic [WIN*LANES-1:0]        pend_bits;
    logic [WIN*LANES*ERR_W-1:0]  pend_err;
    logic [WIN*LANES*FLAG_W-1:0] pend_sd;

    logic [FRAME_W-1:0]          exp_frame_q [$];
    logic [LANES-1:0]            exp_prbs_q  [$];
    logic [WIN*LANES-1:0]        exp_bits_q  [$];
    logic [WIN*LANES*ERR_W-1:0]  exp_err_q   [$];
    logic [WIN*LANES*FLAG_W-1:0] exp_sd_q    [$];

    int credits;
    int drops;
    int errors;
    int records;
    int pending;

    initial begin
        errors  = 0;
        records = 0;
    end

    assign err_count_o  = 32'(errors);
    assign rec_count_o  = 32'(records);
    assign drop_count_o = 32'(drops);
    assign pending_o    = 32'(pending);

    function automatic int count_ones(input logic [LANES-1:0] v);
        int n;
        n = 0;
        for (int i = 0; i < LANES; i++) begin
            if (v[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic compare_field(input string name, input logic [511:0] exp_v,
                                 input logic [511:0] act_v);
        if (exp_v !== act_v) begin
            $display("Error: time %0t signal %s expected %0h actual %0h",
                     $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    // the record on the outputs now was popped at the previous edge
    task automatic check_record();
        if (exp_frame_q.size() == 0) begin
            $display("Error: time %0t, a record came out but none was expected", $time);
            errors++;
        end else begin
            if (credits == 0) begin
                $display("Error: time %0t, a record came out without any credit", $time);
                errors++;
            end else begin
                credits--;
            end
            compare_field("rec_frame_o", exp_frame_q.pop_front(), rec_frame_i);
            compare_field("rec_prbs_o", exp_prbs_q.pop_front(), rec_prbs_i);
            compare_field("rec_bits_o", exp_bits_q.pop_front(), rec_bits_i);
            compare_field("rec_error_o", exp_err_q.pop_front(), rec_error_i);
            compare_field("rec_sdflags_o", exp_sd_q.pop_front(), rec_sdflags_i);
            records++;
        end
    endtask

    always @(posedge clk) begin
        if (!rstb) begin
            for (int i = 0; i < WIN; i++) begin
                bits_h[i] = '0;
                prbs_h[i] = '0;
                err_h[i]  = '0;
                sd_h[i]   = '0;
            end
            frame_n  = '0;
            wr_pend  = 1'b0;
            credit_d = 1'b0;
            credits  = 0;
            drops    = 0;
            pending  = 0;
            exp_frame_q.delete();
            exp_prbs_q.delete();
            exp_bits_q.delete();
            exp_err_q.delete();
            exp_sd_q.delete();
        end else begin
            compare_field("drop_count_o", 512'(drops), 512'(drop_count_i));
            if (rec_valid_i === 1'b1) begin
                check_record();
            end
            // a trigger found at the last edge is stored at this one unless the store is full
            if (wr_pend) begin
                if (exp_frame_q.size() == DEPTH) begin
                    if (drops < DROP_MAX) begin
                        drops++;
                    end
                end else begin
                    exp_frame_q.push_back(pend_frame);
                    exp_prbs_q.push_back(pend_prbs);
                    exp_bits_q.push_back(pend_bits);
                    exp_err_q.push_back(pend_err);
                    exp_sd_q.push_back(pend_sd);
                end
            end
            // a returned credit can only pay for a record checked two edges later
            if (credit_d) begin
                credits++;
            end
            credit_d = credit_i;
            for (int i = WIN - 1; i > 0; i--) begin
                bits_h[i] = bits_h[i-1];
                prbs_h[i] = prbs_h[i-1];
                err_h[i]  = err_h[i-1];
                sd_h[i]   = sd_h[i-1];
            end
            bits_h[0] = sliced_bits_i;
            prbs_h[0] = prbs_flags_i;
            err_h[0]  = est_error_i;
            sd_h[0]   = sd_flags_i;
            // frame n-1 now has its successor, so its window is complete
            wr_pend    = count_ones(prbs_h[1]) > int'(mode_i);
            pend_frame = frame_n - FRAME_W'(1);
            pend_prbs  = prbs_h[1];
            pend_bits  = {bits_h[0], bits_h[1], bits_h[2]};
            pend_err   = {err_h[0], err_h[1], err_h[2]};
            pend_sd    = {sd_h[0], sd_h[1], sd_h[2]};
            frame_n    = frame_n + FRAME_W'(1);
            pending    = exp_frame_q.size() + int'(wr_pend);
        end
    end

endmodule

//--- tb/tb_errt.sv
`timescale 1ns/10ps

module tb_errt
    import errt_pkg::*;
();

    localparam int DRAIN_LIMIT = 400;

    logic                         clk;
    logic                         rstb;
    logic [MODE_W-1:0]            mode_i;
    logic [LANES-1:0]             prbs_flags_i;
    logic [LANES-1:0]             sliced_bits_i;
    logic [LANES-1:0][ERR_W-1:0]  est_error_i;
    logic [LANES-1:0][FLAG_W-1:0] sd_flags_i;
    logic                         credit_i;
    logic                         rec_valid_o;
    logic [FRAME_W-1:0]           rec_frame_o;
    logic [LANES-1:0]             rec_prbs_o;
    logic [WIN*LANES-1:0]         rec_bits_o;
    logic [WIN*LANES*ERR_W-1:0]   rec_error_o;
    logic [WIN*LANES*FLAG_W-1:0]  rec_sdflags_o;
    logic [DROP_W-1:0]            drop_count_o;

    logic [31:0] chk_errors;
    logic [31:0] chk_records;
    logic [31:0] chk_drops;
    logic [31:0] chk_pending;
    logic [31:0] seed;
    int          outstanding;
    int          tb_errors;
    int          total;
    int          base;

    errt_top #(
        .LANES      (LANES),
        .ERR_W      (ERR_W),
        .FLAG_W     (FLAG_W),
        .ADDR_W     (ADDR_W),
        .CREDIT_MAX (CREDIT_MAX)
    ) u_dut (
        .clk           (clk),
        .rstb          (rstb),
        .mode_i        (mode_i),
        .prbs_flags_i  (prbs_flags_i),
        .sliced_bits_i (sliced_bits_i),
        .est_error_i   (est_error_i),
        .sd_flags_i    (sd_flags_i),
        .credit_i      (credit_i),
        .rec_valid_o   (rec_valid_o),
        .rec_frame_o   (rec_frame_o),
        .rec_prbs_o    (rec_prbs_o),
        .rec_bits_o    (rec_bits_o),
        .rec_error_o   (rec_error_o),
        .rec_sdflags_o (rec_sdflags_o),
        .drop_count_o  (drop_count_o)
    );

    errt_checker #(
        .LANES  (LANES),
        .ERR_W  (ERR_W),
        .FLAG_W (FLAG_W),
        .ADDR_W (ADDR_W)
    ) u_chk (
        .clk           (clk),
        .rstb          (rstb),
        .mode_i        (mode_i),
        .prbs_flags_i  (prbs_flags_i),
        .sliced_bits_i (sliced_bits_i),
        .est_error_i   (est_error_i),
        .sd_flags_i    (sd_flags_i),
        .credit_i      (credit_i),
        .rec_valid_i   (rec_valid_o),
        .rec_frame_i   (rec_frame_o),
        .rec_prbs_i    (rec_prbs_o),
        .rec_bits_i    (rec_bits_o),
        .rec_error_i   (rec_error_o),
        .rec_sdflags_i (rec_sdflags_o),
        .drop_count_i  (drop_count_o),
        .err_count_o   (chk_errors),
        .rec_count_o   (chk_records),
        .drop_count_o  (chk_drops),
        .pending_o     (chk_pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // credits handed out minus records received, kept at or below CREDIT_MAX
    always @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(credit_i) - int'(rec_valid_o);
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic apply_reset();
        rstb     = 1'b0;
        credit_i = 1'b0;
        repeat (5) @(negedge clk);
        rstb = 1'b1;
    endtask

    // dens sets the flag density in sixteenths, cred_pct the credit chance in 128ths
    task automatic drive_frame(input logic [MODE_W-1:0] mode, input int dens,
                               input int cred_pct);
        logic [31:0] r;
        @(negedge clk);
        mode_i = mode;
        for (int i = 0; i < LANES; i++) begin
            r = next_rand();
            prbs_flags_i[i]  = (int'(r[31:28]) < dens);
            sliced_bits_i[i] = r[27];
            est_error_i[i]   = r[12 +: ERR_W];
            sd_flags_i[i]    = r[24 +: FLAG_W];
        end
        r = next_rand();
        credit_i = (outstanding < CREDIT_MAX) && (int'(r[31:25]) < cred_pct);
    endtask

    task automatic run_phase(input int frames, input logic [MODE_W-1:0] mode,
                             input int dens, input int cred_pct);
        repeat (frames) drive_frame(mode, dens, cred_pct);
    endtask

    task automatic drain_store();
        int waited;
        waited = 0;
        run_phase(4, MODE_W'(3), 0, 0);
        while (chk_pending != 0 && waited < DRAIN_LIMIT) begin
            drive_frame(MODE_W'(3), 0, 128);
            waited++;
        end
        if (chk_pending != 0) begin
            $display("Timeout: %0d records were still stored after %0d cycles of credits",
                     chk_pending, waited);
            tb_errors++;
        end
    endtask

    initial begin
        seed          = 32'hf901;
        tb_errors     = 0;
        mode_i        = '0;
        prbs_flags_i  = '0;
        sliced_bits_i = '0;
        est_error_i   = '0;
        sd_flags_i    = '0;
        apply_reset();

        // every mode twice, with random density and credit rate per phase
        base = int'(next_rand() >> 30);
        for (int ph = 0; ph < 8; ph++) begin
            run_phase(120, MODE_W'(base + ph), 1 + int'(next_rand() >> 29) % 5,
                      int'(next_rand() >> 25));
        end

        // no credits and dense flags fill the store and saturate the drop counter
        run_phase(320, MODE_W'(0), 12, 0);
        drain_store();

        // reset in the middle of traffic, numbering starts again at 0
        run_phase(40, MODE_W'(1), 5, 40);
        apply_reset();
        run_phase(100, MODE_W'(2), 6, 60);
        drain_store();

        repeat (2) @(negedge clk);
        total = int'(chk_errors) + tb_errors + u_dut.u_readout.u_asserts.fail_count;
        $display("Summary: %0d records checked, drop count %0d, %0d errors",
                 chk_records, chk_drops, total);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- flist.f
verilog/errt_pkg.sv
verilog/history_buffer.sv
verilog/error_tracker.sv
verilog/capture_store.sv
verilog/record_readout.sv
verilog/errt_top.sv
tb/errt_asserts.sv
tb/errt_checker.sv
tb/tb_errt.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_errt
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failures found
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
